// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= icache_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== design/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_ctrl
    import mem_pkg::*, icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  req_valid,
    output logic  req_ready,
    input  addr_t req_addr,

    input  logic  flush,

    output logic  cpu_resp_valid,
    input  logic  cpu_resp_ready,
    output word_t cpu_resp_data,

    output logic  fill_valid,
    output addr_t fill_addr,
    input  logic  fill_done,
    input  word_t fill_data
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    line_t  lines [`ICACHE_LINES];
    line_t  cur_line;
    addr_t  addr_q;
    word_t  resp_data_q;
    index_t idx;
    tag_t   tag;
    logic   hit;

    assign idx = addr_q[`ICACHE_INDEX_W+1:2];
    assign tag = addr_q[`ICACHE_ADDR_W-1:`ICACHE_ADDR_W-`ICACHE_TAG_W];

    assign cur_line = lines[idx];
    assign hit      = cur_line.valid && (cur_line.tag == tag);

    // flush wins over a new request in IDLE
    assign req_ready      = (state == IDLE) && !flush;
    assign cpu_resp_valid = (state == RESPOND);
    assign cpu_resp_data  = resp_data_q;
    assign fill_valid     = (state == REFILL);
    assign fill_addr      = addr_q;

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (req_valid && req_ready)
                    state_next = COMPARE;
            COMPARE:
                state_next = hit ? RESPOND : REFILL;
            REFILL:
                if (fill_done)
                    state_next = RESPOND;
            RESPOND:
                if (cpu_resp_ready)
                    state_next = IDLE;
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    // only the valid bits see reset and flush
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `ICACHE_LINES; i++)
                lines[i].valid <= 1'b0;
        end
        else if (state == IDLE && flush)
        begin
            for (int i = 0; i < `ICACHE_LINES; i++)
                lines[i].valid <= 1'b0;
        end
        else if (state == REFILL && fill_done)
        begin
            lines[idx] <= '{valid: 1'b1, tag: tag, data: fill_data};
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
            addr_q <= req_addr;
    end

    always_ff @(posedge clk)
    begin
        if (state == COMPARE && hit)
            resp_data_q <= cur_line.data;
        else if (state == REFILL && fill_done)
            resp_data_q <= fill_data;
    end

endmodule

// ==== design/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// word address, byte offset bits 1:0 unused
`define ICACHE_ADDR_W 32

// index from address bits 5:2
`define ICACHE_INDEX_W 4

`define ICACHE_LINES 16

// tag from address bits 31:6
`define ICACHE_TAG_W 26

`endif

// ==== design/icache_pkg.sv ====
`include "icache_defines.svh"

package icache_pkg;

    import mem_pkg::*;

    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;

    // one direct-mapped line, single word
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } line_t;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

// ==== design/icache_top.sv ====
`timescale 1ns/1ps

module icache_top
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  cpu_req_valid,
    output logic  cpu_req_ready,
    input  addr_t cpu_req_addr,

    output logic  cpu_resp_valid,
    input  logic  cpu_resp_ready,
    output word_t cpu_resp_data,

    input  logic  flush,

    output logic  mem_req_valid,
    input  logic  mem_req_ready,
    output addr_t mem_req_addr,
    input  word_t mem_rdata
);

    logic  req_valid;
    logic  req_ready;
    addr_t req_addr;

    logic  fill_valid;
    addr_t fill_addr;
    logic  fill_done;
    word_t fill_data;

    // fetch address slot
    req_slot #(
        .payload_t (addr_t)
    ) u_req_slot (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (cpu_req_valid),
        .in_ready  (cpu_req_ready),
        .in_data   (cpu_req_addr),
        .out_valid (req_valid),
        .out_ready (req_ready),
        .out_data  (req_addr)
    );

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_addr       (req_addr),
        .flush          (flush),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_ready (cpu_resp_ready),
        .cpu_resp_data  (cpu_resp_data),
        .fill_valid     (fill_valid),
        .fill_addr      (fill_addr),
        .fill_done      (fill_done),
        .fill_data      (fill_data)
    );

    refill_port u_refill (
        .clk           (clk),
        .rst           (rst),
        .fill_valid    (fill_valid),
        .fill_addr     (fill_addr),
        .fill_done     (fill_done),
        .fill_data     (fill_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_rdata     (mem_rdata)
    );

endmodule

// ==== design/mem_pkg.sv ====
`include "icache_defines.svh"

package mem_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

    // instruction word as returned by memory
    typedef logic [31:0] word_t;

endpackage

// ==== design/refill_port.sv ====
`timescale 1ns/1ps

module refill_port
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  fill_valid,
    input  addr_t fill_addr,
    output logic  fill_done,
    output word_t fill_data,

    output logic  mem_req_valid,
    input  logic  mem_req_ready,
    output addr_t mem_req_addr,
    input  word_t mem_rdata
);

    // read outstanding, held through the fill_done cycle
    logic  busy;
    logic  word_valid;
    word_t word_data;

    req_slot #(
        .payload_t (word_t)
    ) u_word_slot (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mem_req_valid && mem_req_ready),
        .in_ready  (),
        .in_data   (mem_rdata),
        .out_valid (word_valid),
        .out_ready (1'b1),
        .out_data  (word_data)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy          <= 1'b0;
            mem_req_valid <= 1'b0;
            fill_done     <= 1'b0;
        end
        else
        begin
            fill_done <= word_valid;
            if (!busy && fill_valid)
            begin
                busy          <= 1'b1;
                mem_req_valid <= 1'b1;
            end
            else if (mem_req_valid && mem_req_ready)
            begin
                mem_req_valid <= 1'b0;
            end
            if (fill_done)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && fill_valid)
            mem_req_addr <= fill_addr;
    end

    always_ff @(posedge clk)
    begin
        if (word_valid)
            fill_data <= word_data;
    end

endmodule

// ==== design/req_slot.sv ====
`timescale 1ns/1ps

module req_slot #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     buf_valid;
    payload_t buf_data;

    // a full slot still takes a new item when the held one leaves
    assign in_ready  = !buf_valid || out_ready;
    assign out_valid = buf_valid || in_valid;
    assign out_data  = buf_valid ? buf_data : in_data;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            buf_valid <= 1'b0;
        end
        else if (buf_valid)
        begin
            if (out_ready)
                buf_valid <= in_valid;
        end
        else
        begin
            // empty: buffer only if downstream stalls
            buf_valid <= in_valid && !out_ready;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready && (buf_valid || !out_ready))
            buf_data <= in_data;
    end

endmodule

// ==== files.f ====
+incdir+design
design/mem_pkg.sv
design/icache_pkg.sv
design/req_slot.sv
design/icache_ctrl.sv
design/refill_port.sv
design/icache_top.sv
sim/icache_assert.sv
sim/icache_tb.sv

// ==== sim/icache_assert.sv ====
`timescale 1ns/1ps

module icache_assert
    import mem_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  cpu_resp_valid,
    input logic  cpu_resp_ready,
    input word_t cpu_resp_data,
    input logic  mem_req_valid,
    input logic  mem_req_ready,
    input addr_t mem_req_addr
);

    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else $error("memory request dropped or changed while waiting");

    assert property (@(posedge clk) rst |=> !mem_req_valid)
        else $error("memory request raised during reset");

    // response held under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        cpu_resp_valid && !cpu_resp_ready |=> cpu_resp_valid && $stable(cpu_resp_data))
        else $error("response dropped or changed under back-pressure");

endmodule

bind icache_top icache_assert u_assert (.*);

// ==== sim/icache_stim.txt ====
# op (R read, F flush), word address in hex, expected miss (1) or hit (0)
# index is address bits 5:2, tag is bits 31:6
R 00001000 1
R 00001000 0
R 00001004 1
R 00001004 0
R 00001040 1
R 00001000 1
R 00001040 1
R 00001000 1
R 00001008 1
R 0000100C 1
R 00001008 0
R 0000100C 0
F 00000000 0
R 00001008 1
R 0000100C 1
R 00001004 1
R 00001004 0
R ABCD0010 1
R ABCD0010 0
R 00001010 1
R ABCD0010 1
R 00001010 1
R 7FFFFFFC 1
R 7FFFFFFC 0
F 00000000 0
R 00001000 1
R 00001000 0
R 7FFFFFFC 1

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb
    import mem_pkg::*;
;

    // a hit shows cpu_resp_valid on the second edge after the fetch handshake
    localparam int HIT_LATENCY = 2;
    localparam int CYCLES_PER_OP = 200;

    logic  clk;
    logic  rst;
    logic  cpu_req_valid;
    logic  cpu_req_ready;
    addr_t cpu_req_addr;
    logic  cpu_resp_valid;
    logic  cpu_resp_ready;
    word_t cpu_resp_data;
    logic  flush;
    logic  mem_req_valid;
    logic  mem_req_ready;
    addr_t mem_req_addr;
    word_t mem_rdata;

    int    errors;
    int    checks;
    int    mem_reads;
    int    n_ops;
    int    mem_delay;
    bit    mem_busy;
    addr_t cur_addr;

    byte   op_q[$];
    addr_t addr_q[$];
    int    miss_q[$];

    // reference valid/tag model
    bit                 model_valid [16];
    logic [25:0]        model_tag [16];

    icache_top dut (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_ready (cpu_resp_ready),
        .cpu_resp_data  (cpu_resp_data),
        .flush          (flush),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_rdata      (mem_rdata)
    );

    always #20 clk = ~clk;

    function automatic word_t mem_word(input addr_t a);
        return {~a[31:16], a[15:0]};
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR %0t: %s: got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    // memory model with 0 to 3 cycles of ready delay
    always @(negedge clk)
    begin
        if (rst)
        begin
            mem_req_ready = 1'b0;
            mem_busy = 1'b0;
        end
        else if (mem_req_ready)
        begin
            mem_req_ready = 1'b0;
        end
        else if (mem_req_valid)
        begin
            if (!mem_busy)
            begin
                mem_delay = $urandom % 4;
                mem_busy = 1'b1;
            end
            if (mem_delay == 0)
            begin
                mem_req_ready = 1'b1;
                mem_rdata = mem_word(mem_req_addr);
                mem_busy = 1'b0;
            end
            else
            begin
                mem_delay--;
            end
        end
    end

    always @(posedge clk)
    begin
        if (!rst && mem_req_valid && mem_req_ready)
        begin
            mem_reads++;
            check_equal(mem_req_addr, cur_addr, "memory read address");
        end
    end

    task automatic pulse_flush();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        for (int i = 0; i < 16; i++)
            model_valid[i] = 1'b0;
    endtask

    task automatic fetch_and_check(input addr_t addr, input int exp_miss);
        logic [3:0] idx;
        bit         model_hit;
        int         start_reads;
        int         latency;
        int         bp;
        bit         seen;
        bit         done;
        word_t      held;

        idx = addr[5:2];
        model_hit = model_valid[idx] && (model_tag[idx] == addr[31:6]);
        check_equal(model_hit ? 0 : 1, exp_miss, "miss flag in stimulus vs model");
        model_valid[idx] = 1'b1;
        model_tag[idx] = addr[31:6];

        cur_addr = addr;
        start_reads = mem_reads;
        @(negedge clk);
        cpu_req_valid = 1'b1;
        cpu_req_addr = addr;
        do
            @(posedge clk);
        while (!cpu_req_ready);

        seen = 1'b0;
        done = 1'b0;
        latency = 0;
        bp = $urandom % 4;
        while (!done)
        begin
            @(negedge clk);
            cpu_req_valid = 1'b0;
            cpu_resp_ready = (bp == 0);
            if (seen && bp > 0)
                bp--;
            @(posedge clk);
            latency++;
            if (cpu_resp_valid)
            begin
                if (!seen)
                begin
                    seen = 1'b1;
                    held = cpu_resp_data;
                    if (model_hit)
                        check_equal(latency, HIT_LATENCY, "hit latency");
                end
                else
                begin
                    check_equal(cpu_resp_data, held, "response held under back-pressure");
                end
                if (cpu_resp_ready)
                    done = 1'b1;
            end
        end

        check_equal(held, mem_word(addr), "read data");
        check_equal(mem_reads - start_reads, model_hit ? 0 : 1, "memory reads per fetch");
        @(negedge clk);
        cpu_resp_ready = 1'b0;
        @(posedge clk);
        check_equal({31'b0, cpu_resp_valid}, 32'd0, "duplicate response");
    endtask

    task automatic load_stim(output bit ok);
        int    fd;
        string line;
        byte   op;
        addr_t addr;
        int    miss;

        ok = 1'b0;
        fd = $fopen("sim/icache_stim.txt", "r");
        if (fd != 0)
        begin
            ok = 1'b1;
            while ($fgets(line, fd))
            begin
                if (line.len() > 1 && line[0] != "#")
                begin
                    if ($sscanf(line, "%c %h %d", op, addr, miss) == 3)
                    begin
                        op_q.push_back(op);
                        addr_q.push_back(addr);
                        miss_q.push_back(miss);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial
    begin
        wait (n_ops > 0);
        repeat (CYCLES_PER_OP * n_ops + 16) @(posedge clk);
        $display("timeout: the run did not finish in %0d cycles", CYCLES_PER_OP * n_ops);
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        bit ok;
        int seed_ret;

        seed_ret = $urandom(32'h1bca);
        clk = 1'b0;
        rst = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req_addr = '0;
        cpu_resp_ready = 1'b0;
        flush = 1'b0;
        mem_req_ready = 1'b0;
        mem_rdata = '0;
        cur_addr = '0;
        errors = 0;
        checks = 0;
        mem_reads = 0;
        for (int i = 0; i < 16; i++)
            model_valid[i] = 1'b0;

        load_stim(ok);
        if (!ok)
        begin
            $display("could not open the stimulus file sim/icache_stim.txt");
            errors++;
        end
        else
        begin
            n_ops = op_q.size();
            repeat (8) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            foreach (op_q[i])
            begin
                if (op_q[i] == "F")
                    pulse_flush();
                else
                    fetch_and_check(addr_q[i], miss_q[i]);
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
